// ==== pio_sm.f ====
source/pio_pkg.sv
source/pio_scratch.sv
source/pio_isr.sv
source/pio_osr.sv
source/pio_pin_port.sv
source/pio_sequencer.sv
source/pio_exec.sv
source/pio_sm.sv
tb/pio_sm_checker.sv
tb/pio_sm_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pio_sm_tb
BUILD_DIR ?= build
FILELIST  ?= pio_sm.f
VFLAGS    ?= --assert --timing
PASS_MSG  := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/pio_sm_tb.sv ====
// ==========================================================
// Random programs and configs in three reset phases of 1000 cycles.
// FIFO flags toggle at random; tx_data follows a pull counter
// ==========================================================
module pio_sm_tb
  import pio_pkg::*;
();

  logic               clk;
  logic               rst;
  logic               en;
  sm_cfg_t            cfg;
  logic [INSTR_W-1:0] prog [2**PC_W];
  logic [INSTR_W-1:0] instr;
  logic [DATA_W-1:0]  input_pins;
  logic [DATA_W-1:0]  tx_data;
  logic               tx_empty;
  logic               rx_full;
  logic [PC_W-1:0]    pc;
  logic               push;
  logic               pull;
  logic [DATA_W-1:0]  rx_data;
  logic [DATA_W-1:0]  output_pins;
  logic [DATA_W-1:0]  pin_dirs;
  logic [DATA_W-1:0]  pull_count;
  int                 checks;
  int                 errors;
  int                 timeouts;

  assign instr = prog[pc];  // Combinational program store

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  pio_sm i_dut (
    .clk(clk), .rst(rst), .en(en), .cfg(cfg), .instr(instr), .input_pins(input_pins),
    .tx_data(tx_data), .tx_empty(tx_empty), .rx_full(rx_full), .pc(pc), .push(push),
    .pull(pull), .rx_data(rx_data), .output_pins(output_pins), .pin_dirs(pin_dirs)
  );

  pio_sm_checker i_checker (
    .clk(clk), .rst(rst), .en(en), .input_pins(input_pins), .tx_data(tx_data),
    .tx_empty(tx_empty), .rx_full(rx_full), .pc(pc), .push(push), .pull(pull),
    .rx_data(rx_data), .output_pins(output_pins), .pin_dirs(pin_dirs),
    .checks(checks), .errors(errors)
  );

  always @(posedge clk) begin
    if (rst) begin
      pull_count <= '0;
    end else if (pull) begin
      pull_count <= pull_count + 32'd1;
    end
  end

  // Sources 0 to 3, 6 and 7
  function automatic logic [2:0] legal_src();
    logic [2:0] s;
    s = 3'($urandom_range(5, 0));
    return (s >= 3'd4) ? s + 3'd2 : s;
  endfunction

  function automatic logic [INSTR_W-1:0] random_instr();
    instr_u     ins;
    logic [2:0] d;
    ins = INSTR_W'($urandom);
    case ($urandom_range(5, 0))
      0: ins.jmp_v.opcode = OP_JMP;
      1: begin
        ins.shift_v.opcode = OP_IN;
        ins.shift_v.sel    = legal_src();
      end
      2: begin
        ins.shift_v.opcode = OP_OUT;
        ins.shift_v.sel    = 3'($urandom_range(6, 0));  // No EXEC
      end
      3: begin
        ins.fifo_v.opcode = OP_PUSH_PULL;
        ins.fifo_v.rsvd   = 1'b0;
        ins.fifo_v.unused = '0;
      end
      4: begin
        d = 3'($urandom_range(6, 0));
        ins.mov_v.opcode = OP_MOV;
        ins.mov_v.dest   = dst_e'((d >= 3'd4) ? d + 3'd1 : d);  // Skip EXEC slot
        ins.mov_v.mov_op = mov_op_e'(2'($urandom_range(2, 0)));
        ins.mov_v.src    = src_e'(legal_src());
      end
      default: begin
        d = 3'($urandom_range(3, 0));
        ins.set_v.opcode = OP_SET;
        ins.set_v.dest   = dst_e'((d == 3'd3) ? 3'd4 : d);
      end
    endcase
    ins.jmp_v.delay = ($urandom_range(3, 0) == 0) ? DELAY_W'($urandom_range(3, 1)) : '0;
    return ins;
  endfunction

  function automatic sm_cfg_t random_cfg();
    sm_cfg_t         c;
    logic [PC_W-1:0] t;
    c.wrap_target     = PC_W'($urandom);
    c.wrap_end        = PC_W'($urandom);
    c.out_base        = PIN_W'($urandom);
    c.out_count       = CNT_W'($urandom_range(32, 0));
    c.set_base        = PIN_W'($urandom);
    c.set_count       = 3'($urandom);
    c.in_base         = PIN_W'($urandom);
    c.jmp_pin         = PIN_W'($urandom);
    c.in_shift_right  = 1'($urandom);
    c.out_shift_right = 1'($urandom);
    c.osr_threshold   = 5'($urandom);
    if (c.wrap_target > c.wrap_end) begin
      t             = c.wrap_target;
      c.wrap_target = c.wrap_end;
      c.wrap_end    = t;
    end
    return c;
  endfunction

  task automatic drive_inputs();
    en         = ($urandom_range(7, 0) != 0);  // Mostly running
    input_pins = $urandom;
    tx_data    = pull_count * 32'h9e37_79b1;   // Counter spread over all bits
    if ($urandom_range(3, 0) == 0) begin
      tx_empty = ~tx_empty;
    end
    if ($urandom_range(3, 0) == 0) begin
      rx_full = ~rx_full;
    end
  endtask

  task automatic start_phase();
    int n;
    rst = 1'b1;
    en  = 1'b0;
    cfg = random_cfg();
    for (int i = 0; i < 2**PC_W; i++) begin
      prog[i] = random_instr();
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    n   = 0;
    while (!(pc === '0 && push === 1'b0 && pull === 1'b0) && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!(pc === '0 && push === 1'b0 && pull === 1'b0)) begin
      $display("Timeout: DUT did not leave reset with pc at 0 and no FIFO strobe");
      timeouts++;
    end
  endtask

  task automatic run_cycles(input int count);
    for (int i = 0; i < count; i++) begin
      drive_inputs();
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'h70c6_10eb));
    rst        = 1'b1;
    en         = 1'b0;
    cfg        = '0;
    input_pins = '0;
    tx_data    = '0;
    tx_empty   = 1'b1;
    rx_full    = 1'b0;
    timeouts   = 0;
    for (int i = 0; i < 2**PC_W; i++) begin
      prog[i] = '0;
    end
    for (int p = 0; p < 3 && timeouts == 0; p++) begin
      start_phase();
      if (timeouts == 0) begin
        run_cycles(1000);
      end
    end
    @(negedge clk);
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== tb/pio_sm_checker.sv ====
// ==========================================================
// Cycle model of one state machine, compared at each rising edge.
// Program and config are read from the testbench top
// ==========================================================
module pio_sm_checker
  import pio_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              en,
  input  logic [DATA_W-1:0] input_pins,
  input  logic [DATA_W-1:0] tx_data,
  input  logic              tx_empty,
  input  logic              rx_full,
  input  logic [PC_W-1:0]   pc,
  input  logic              push,
  input  logic              pull,
  input  logic [DATA_W-1:0] rx_data,
  input  logic [DATA_W-1:0] output_pins,
  input  logic [DATA_W-1:0] pin_dirs,
  output int                checks,
  output int                errors
);

  sm_cfg_t            cfg;
  logic [PC_W-1:0]    m_pc;
  logic [DELAY_W-1:0] m_delay;
  logic [DATA_W-1:0]  m_x;
  logic [DATA_W-1:0]  m_y;
  logic [DATA_W-1:0]  m_isr;
  logic [DATA_W-1:0]  m_osr;
  int                 m_osr_cnt;
  logic [DATA_W-1:0]  m_pins;
  logic [DATA_W-1:0]  m_dirs;

  assign cfg = pio_sm_tb.cfg;

  function automatic logic [DATA_W-1:0] keep_low(input logic [DATA_W-1:0] v, input int n);
    logic [DATA_W-1:0] r;
    r = '0;
    for (int i = 0; i < n && i < DATA_W; i++) begin
      r[i] = v[i];
    end
    return r;
  endfunction

  // Bit i of v lands on pin (base + i) mod 32 for i below cnt
  function automatic logic [DATA_W-1:0] write_pins(input logic [DATA_W-1:0] old,
                                                   input logic [DATA_W-1:0] v,
                                                   input logic [PIN_W-1:0]  base,
                                                   input int                cnt);
    logic [DATA_W-1:0] r;
    r = old;
    for (int i = 0; i < cnt && i < DATA_W; i++) begin
      r[(int'(base) + i) % DATA_W] = v[i];
    end
    return r;
  endfunction

  function automatic int add_count(input int c, input int n);
    return (c + n > DATA_W) ? DATA_W : c + n;  // Saturates at 32
  endfunction

  function automatic logic [DATA_W-1:0] read_src(input logic [2:0] code);
    logic [DATA_W-1:0] r;
    r = '0;
    case (code)
      SRC_PINS: begin
        for (int i = 0; i < DATA_W; i++) begin
          r[i] = input_pins[(int'(cfg.in_base) + i) % DATA_W];  // in_base becomes bit 0
        end
      end
      SRC_X:   r = m_x;
      SRC_Y:   r = m_y;
      SRC_ISR: r = m_isr;
      SRC_OSR: r = m_osr;
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic jmp_taken(input jmp_cond_e c);
    int   thr;
    logic r;
    thr = (cfg.osr_threshold == '0) ? DATA_W : int'(cfg.osr_threshold);
    case (c)
      COND_ALWAYS: r = 1'b1;
      COND_X_ZERO: r = (m_x == '0);
      COND_X_DEC:  r = (m_x != '0);
      COND_Y_ZERO: r = (m_y == '0);
      COND_Y_DEC:  r = (m_y != '0);
      COND_X_NE_Y: r = (m_x != m_y);
      COND_PIN:    r = input_pins[cfg.jmp_pin];
      default:     r = (m_osr_cnt < thr);  // OSR not yet exhausted
    endcase
    return r;
  endfunction

  task automatic compare(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: DUT %h, model %h at time %0t", name, got, exp, $time);
    end
  endtask

  task automatic reset_model();
    m_pc      = '0;
    m_delay   = '0;
    m_x       = '0;
    m_y       = '0;
    m_isr     = '0;
    m_osr     = '0;
    m_osr_cnt = 0;
    m_pins    = '0;
    m_dirs    = '0;
  endtask

  task automatic execute(input instr_u ins);
    logic              stall;
    logic              take_jmp;
    logic [PC_W-1:0]   target;
    logic [DATA_W-1:0] val;
    int                n;
    stall    = 1'b0;
    take_jmp = 1'b0;
    target   = ins.jmp_v.addr;
    n        = (ins.shift_v.bit_count == '0) ? DATA_W : int'(ins.shift_v.bit_count);
    case (ins.jmp_v.opcode)
      OP_JMP: begin
        take_jmp = jmp_taken(ins.jmp_v.cond);
        if (ins.jmp_v.cond == COND_X_DEC) begin
          m_x = m_x - 32'd1;  // Post-decrement, also from zero
        end
        if (ins.jmp_v.cond == COND_Y_DEC) begin
          m_y = m_y - 32'd1;
        end
      end
      OP_IN: begin
        val = keep_low(read_src(ins.shift_v.sel), n);
        if (cfg.in_shift_right) begin
          m_isr = (m_isr >> n) | (val << (DATA_W - n));
        end else begin
          m_isr = (m_isr << n) | val;
        end
      end
      OP_OUT: begin
        if (cfg.out_shift_right) begin
          val   = keep_low(m_osr, n);
          m_osr = m_osr >> n;
        end else begin
          val   = m_osr >> (DATA_W - n);  // Top n bits
          m_osr = m_osr << n;
        end
        m_osr_cnt = add_count(m_osr_cnt, n);
        case (dst_e'(ins.shift_v.sel))
          DST_PINS:    m_pins = write_pins(m_pins, val, cfg.out_base, int'(cfg.out_count));
          DST_X:       m_x = val;
          DST_Y:       m_y = val;
          DST_PINDIRS: m_dirs = write_pins(m_dirs, val, cfg.out_base, int'(cfg.out_count));
          DST_PC: begin
            take_jmp = 1'b1;
            target   = val[PC_W-1:0];
          end
          DST_ISR:     m_isr = val;
          default: ;
        endcase
      end
      OP_PUSH_PULL: begin
        if (!ins.fifo_v.is_pull) begin
          stall = ins.fifo_v.block && rx_full;
          if (!stall) begin
            m_isr = '0;  // Pushed, or dropped on a full FIFO
          end
        end else begin
          stall = ins.fifo_v.block && tx_empty;
          if (!stall) begin
            m_osr     = tx_empty ? m_x : tx_data;
            m_osr_cnt = 0;
          end
        end
      end
      OP_MOV: begin
        val = read_src(ins.mov_v.src);
        if (ins.mov_v.mov_op == MOV_INVERT) begin
          val = ~val;
        end else if (ins.mov_v.mov_op == MOV_REVERSE) begin
          val = reverse_bits(val);
        end
        case (ins.mov_v.dest)
          DST_PINS: m_pins = write_pins(m_pins, val, cfg.out_base, int'(cfg.out_count));
          DST_X:    m_x = val;
          DST_Y:    m_y = val;
          DST_PC: begin
            take_jmp = 1'b1;
            target   = val[PC_W-1:0];
          end
          DST_ISR:  m_isr = val;
          DST_OSR: begin
            m_osr     = val;
            m_osr_cnt = 0;
          end
          default: ;
        endcase
      end
      OP_SET: begin
        val = DATA_W'(ins.set_v.data);
        case (ins.set_v.dest)
          DST_PINS:    m_pins = write_pins(m_pins, val, cfg.set_base, int'(cfg.set_count));
          DST_X:       m_x = val;
          DST_Y:       m_y = val;
          DST_PINDIRS: m_dirs = write_pins(m_dirs, val, cfg.set_base, int'(cfg.set_count));
          default: ;
        endcase
      end
      default: ;  // WAIT and IRQ do nothing
    endcase
    if (!stall) begin
      if (take_jmp) begin
        m_pc = target;
      end else if (m_pc == cfg.wrap_end) begin
        m_pc = cfg.wrap_target;
      end else begin
        m_pc = m_pc + PC_W'(1);
      end
      m_delay = ins.jmp_v.delay;
    end
  endtask

  task automatic check_cycle();
    instr_u ins;
    logic   issue;
    logic   exp_push;
    logic   exp_pull;
    ins      = pio_sm_tb.prog[m_pc];
    issue    = en && (m_delay == '0);
    exp_push = issue && (ins.fifo_v.opcode == OP_PUSH_PULL) && !ins.fifo_v.is_pull && !rx_full;
    exp_pull = issue && (ins.fifo_v.opcode == OP_PUSH_PULL) && ins.fifo_v.is_pull && !tx_empty;
    compare("pc", DATA_W'(pc), DATA_W'(m_pc));
    compare("push", DATA_W'(push), DATA_W'(exp_push));
    compare("pull", DATA_W'(pull), DATA_W'(exp_pull));
    if (exp_push) begin
      compare("rx_data", rx_data, m_isr);
    end
    compare("output_pins", output_pins, m_pins);
    compare("pin_dirs", pin_dirs, m_dirs);
    if (issue) begin
      execute(ins);
    end else if (en) begin
      m_delay = m_delay - DELAY_W'(1);  // Idle delay cycle
    end
  endtask

  // Reads see the DUT state from before this edge
  always @(posedge clk) begin
    if (rst) begin
      reset_model();
    end else begin
      check_cycle();
    end
  end

endmodule

// ==== source/pio_sm.sv ====
// ==========================================================
// PIO state machine top. cfg must stay stable while en is high,
// instr answers pc in the same cycle
// ==========================================================
module pio_sm
  import pio_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  sm_cfg_t            cfg,
  input  logic [INSTR_W-1:0] instr,
  input  logic [DATA_W-1:0]  input_pins,
  input  logic [DATA_W-1:0]  tx_data,
  input  logic               tx_empty,
  input  logic               rx_full,
  output logic [PC_W-1:0]    pc,
  output logic               push,
  output logic               pull,
  output logic [DATA_W-1:0]  rx_data,
  output logic [DATA_W-1:0]  output_pins,
  output logic [DATA_W-1:0]  pin_dirs
);

  logic               issue;
  logic               retire;
  logic [DELAY_W-1:0] delay;
  sm_wb_t             wb;
  logic [DATA_W-1:0]  x_q;
  logic [DATA_W-1:0]  y_q;
  logic [DATA_W-1:0]  isr_q;
  logic [DATA_W-1:0]  osr_q;
  logic [DATA_W-1:0]  out_bits;
  logic [CNT_W-1:0]   isr_count;
  logic [CNT_W-1:0]   osr_count;

  pio_sequencer i_sequencer (
    .clk(clk), .rst(rst), .en(en), .retire(retire), .wb(wb), .delay(delay),
    .wrap_target(cfg.wrap_target), .wrap_end(cfg.wrap_end), .issue(issue), .pc(pc)
  );

  pio_exec i_exec (
    .issue(issue), .instr(instr), .cfg(cfg), .x(x_q), .y(y_q), .isr(isr_q), .osr(osr_q),
    .out_bits(out_bits), .input_pins(input_pins), .tx_data(tx_data),
    .isr_count(isr_count), .osr_count(osr_count), .tx_empty(tx_empty), .rx_full(rx_full),
    .wb(wb), .retire(retire), .push(push), .pull(pull), .rx_data(rx_data), .delay(delay)
  );

  pio_scratch i_x (
    .clk(clk), .rst(rst), .load(wb.set_x), .dec(wb.dec_x), .value(wb.value), .q(x_q)
  );

  pio_scratch i_y (
    .clk(clk), .rst(rst), .load(wb.set_y), .dec(wb.dec_y), .value(wb.value), .q(y_q)
  );

  pio_isr i_isr (
    .clk(clk), .rst(rst), .load(wb.load_isr), .shift(wb.shift_isr),
    .in_shift_right(cfg.in_shift_right), .value(wb.value), .bit_count(wb.bit_count),
    .q(isr_q), .count(isr_count)
  );

  pio_osr i_osr (
    .clk(clk), .rst(rst), .load(wb.load_osr), .shift(wb.shift_osr),
    .out_shift_right(cfg.out_shift_right), .bit_count(wb.bit_count), .value(wb.value),
    .q(osr_q), .out_bits(out_bits), .count(osr_count)
  );

  pio_pin_port i_pin_port (
    .clk(clk), .rst(rst), .pins(wb.pins), .dirs(wb.dirs), .value(wb.value),
    .pin_base(wb.pin_base), .pin_count(wb.pin_count),
    .output_pins(output_pins), .pin_dirs(pin_dirs)
  );

endmodule

// ==== source/pio_exec.sv ====
// ==========================================================
// Combinational decode and execute. WAIT and IRQ run as NOP,
// MOV and OUT to the EXEC slots do nothing
// ==========================================================
module pio_exec
  import pio_pkg::*;
(
  input  logic               issue,
  input  instr_u             instr,
  input  sm_cfg_t            cfg,
  input  logic [DATA_W-1:0]  x,
  input  logic [DATA_W-1:0]  y,
  input  logic [DATA_W-1:0]  isr,
  input  logic [DATA_W-1:0]  osr,
  input  logic [DATA_W-1:0]  out_bits,
  input  logic [DATA_W-1:0]  input_pins,
  input  logic [DATA_W-1:0]  tx_data,
  input  logic [CNT_W-1:0]   isr_count,
  input  logic [CNT_W-1:0]   osr_count,
  input  logic               tx_empty,
  input  logic               rx_full,
  output sm_wb_t             wb,
  output logic               retire,
  output logic               push,
  output logic               pull,
  output logic [DATA_W-1:0]  rx_data,
  output logic [DELAY_W-1:0] delay
);

  logic [DATA_W-1:0] in_pins;
  src_e              src_sel;
  logic [DATA_W-1:0] src_val;
  logic [DATA_W-1:0] mov_val;
  logic [CNT_W-1:0]  shift_n;
  logic [CNT_W-1:0]  osr_limit;
  logic              cond_met;
  logic              stall;

  assign in_pins   = rotate_left(input_pins, PIN_W'(DATA_W - cfg.in_base));  // in_base to bit 0
  assign src_sel   = (instr.mov_v.opcode == OP_MOV) ? instr.mov_v.src : src_e'(instr.shift_v.sel);
  assign shift_n   = (instr.shift_v.bit_count == '0) ? CNT_W'(DATA_W)
                                                     : CNT_W'(instr.shift_v.bit_count);
  assign osr_limit = (cfg.osr_threshold == '0) ? CNT_W'(DATA_W) : CNT_W'(cfg.osr_threshold);

  always_comb begin
    case (src_sel)
      SRC_PINS: src_val = in_pins;
      SRC_X:    src_val = x;
      SRC_Y:    src_val = y;
      SRC_ISR:  src_val = isr;
      SRC_OSR:  src_val = osr;
      default:  src_val = '0;  // NULL and codes 4, 5
    endcase
    case (instr.mov_v.mov_op)
      MOV_INVERT:  mov_val = ~src_val;
      MOV_REVERSE: mov_val = reverse_bits(src_val);
      default:     mov_val = src_val;
    endcase
  end

  always_comb begin
    case (instr.jmp_v.cond)
      COND_ALWAYS:   cond_met = 1'b1;
      COND_X_ZERO:   cond_met = (x == '0);
      COND_X_DEC:    cond_met = (x != '0);  // Tested before the decrement
      COND_Y_ZERO:   cond_met = (y == '0);
      COND_Y_DEC:    cond_met = (y != '0);
      COND_X_NE_Y:   cond_met = (x != y);
      COND_PIN:      cond_met = input_pins[cfg.jmp_pin];
      COND_NOT_OSRE: cond_met = (osr_count < osr_limit);
      default:       cond_met = 1'b0;
    endcase
  end

  // Stall only arises where no register strobe is set, so strobes follow retire
  always_comb begin
    wb    = '0;
    stall = 1'b0;
    push  = 1'b0;
    pull  = 1'b0;
    if (issue) begin
      case (instr.jmp_v.opcode)
        OP_JMP: begin
          wb.value = DATA_W'(instr.jmp_v.addr);
          wb.jmp   = cond_met;
          wb.dec_x = (instr.jmp_v.cond == COND_X_DEC);  // Decrements even at zero
          wb.dec_y = (instr.jmp_v.cond == COND_Y_DEC);
        end
        OP_IN: begin
          wb.value     = src_val;
          wb.bit_count = shift_n;
          wb.shift_isr = 1'b1;
        end
        OP_OUT: begin
          wb.value     = out_bits;
          wb.bit_count = shift_n;
          wb.shift_osr = 1'b1;
          wb.pin_base  = cfg.out_base;
          wb.pin_count = cfg.out_count;
          case (dst_e'(instr.shift_v.sel))
            DST_PINS:    wb.pins     = 1'b1;
            DST_X:       wb.set_x    = 1'b1;
            DST_Y:       wb.set_y    = 1'b1;
            DST_PINDIRS: wb.dirs     = 1'b1;
            DST_PC:      wb.jmp      = 1'b1;
            DST_ISR:     wb.load_isr = 1'b1;  // Count becomes n
            default: ;                        // NULL just discards
          endcase
        end
        OP_PUSH_PULL: begin
          if (!instr.fifo_v.is_pull) begin
            stall       = instr.fifo_v.block && rx_full;
            push        = !rx_full;
            wb.load_isr = !stall;  // ISR cleared, pushed or dropped
          end else begin
            stall       = instr.fifo_v.block && tx_empty;
            pull        = !tx_empty;
            wb.load_osr = !stall;
            wb.value    = tx_empty ? x : tx_data;  // Empty non-blocking pull takes X
          end
        end
        OP_MOV: begin
          wb.value     = mov_val;
          wb.pin_base  = cfg.out_base;
          wb.pin_count = cfg.out_count;
          case (instr.mov_v.dest)
            DST_PINS: wb.pins     = 1'b1;
            DST_X:    wb.set_x    = 1'b1;
            DST_Y:    wb.set_y    = 1'b1;
            DST_PC:   wb.jmp      = 1'b1;
            DST_ISR:  wb.load_isr = 1'b1;
            DST_OSR:  wb.load_osr = 1'b1;
            default: ;
          endcase
        end
        OP_SET: begin
          wb.value     = DATA_W'(instr.set_v.data);
          wb.pin_base  = cfg.set_base;
          wb.pin_count = CNT_W'(cfg.set_count);
          case (instr.set_v.dest)
            DST_PINS:    wb.pins  = 1'b1;
            DST_X:       wb.set_x = 1'b1;
            DST_Y:       wb.set_y = 1'b1;
            DST_PINDIRS: wb.dirs  = 1'b1;
            default: ;
          endcase
        end
        default: ;  // WAIT, IRQ
      endcase
    end
  end

  assign retire  = issue && !stall;
  assign rx_data = push ? isr : '0;
  assign delay   = instr.jmp_v.delay;

  // OSRE test needs both shift counts at 32 or below
  always_comb begin
    assert (isr_count <= CNT_W'(DATA_W) && osr_count <= CNT_W'(DATA_W))
      else $error("shift count above 32");
  end

endmodule

// ==== source/pio_sequencer.sv ====
// ==========================================================
// Program counter and delay counter. Everything holds while en is low
// ==========================================================
module pio_sequencer
  import pio_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  logic               retire,
  input  sm_wb_t             wb,
  input  logic [DELAY_W-1:0] delay,
  input  logic [PC_W-1:0]    wrap_target,
  input  logic [PC_W-1:0]    wrap_end,
  output logic               issue,
  output logic [PC_W-1:0]    pc
);

  logic [DELAY_W-1:0] delay_cnt;

  assign issue = en && (delay_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= '0;
      delay_cnt <= '0;
    end else if (en) begin
      if (retire) begin
        if (wb.jmp) begin
          pc <= wb.value[PC_W-1:0];
        end else if (pc == wrap_end) begin
          pc <= wrap_target;
        end else begin
          pc <= pc + 1'b1;
        end
        delay_cnt <= delay;  // Idle cycles after this one
      end else if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end
    end
  end

  // Exec may only retire what was issued
  assert property (@(posedge clk) disable iff (rst) !issue |-> !retire)
    else $error("retire without issue");

endmodule

// ==== source/pio_pin_port.sv ====
// ==========================================================
// Output pin and direction registers with wrapping masked writes
// ==========================================================
module pio_pin_port
  import pio_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              pins,
  input  logic              dirs,
  input  logic [DATA_W-1:0] value,
  input  logic [PIN_W-1:0]  pin_base,
  input  logic [CNT_W-1:0]  pin_count,
  output logic [DATA_W-1:0] output_pins,
  output logic [DATA_W-1:0] pin_dirs
);

  logic [DATA_W-1:0] wr_mask;
  logic [DATA_W-1:0] wr_val;

  // Bit i of value lands on pin (base + i) mod 32
  assign wr_mask = rotate_left(low_mask(pin_count), pin_base);
  assign wr_val  = rotate_left(value, pin_base);

  always_ff @(posedge clk) begin
    if (rst) begin
      output_pins <= '0;
      pin_dirs    <= '0;
    end else begin
      if (pins) begin
        output_pins <= (output_pins & ~wr_mask) | (wr_val & wr_mask);
      end
      if (dirs) begin
        pin_dirs <= (pin_dirs & ~wr_mask) | (wr_val & wr_mask);
      end
    end
  end

endmodule

// ==== source/pio_osr.sv ====
// ==========================================================
// Output shift register. out_bits is valid for the current count
// ==========================================================
module pio_osr
  import pio_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              load,
  input  logic              shift,
  input  logic              out_shift_right,
  input  logic [CNT_W-1:0]  bit_count,
  input  logic [DATA_W-1:0] value,
  output logic [DATA_W-1:0] q,
  output logic [DATA_W-1:0] out_bits,
  output logic [CNT_W-1:0]  count
);

  logic [CNT_W:0] sum;

  // Right takes the bottom n bits, left the top n
  assign out_bits = out_shift_right ? (q & low_mask(bit_count))
                                    : (q >> (DATA_W - bit_count));
  assign sum      = {1'b0, count} + {1'b0, bit_count};

  always_ff @(posedge clk) begin
    if (rst) begin
      q     <= '0;
      count <= '0;
    end else if (load) begin
      q     <= value;
      count <= '0;  // Full
    end else if (shift) begin
      q     <= out_shift_right ? (q >> bit_count) : (q << bit_count);
      count <= (sum > (CNT_W + 1)'(DATA_W)) ? CNT_W'(DATA_W) : sum[CNT_W-1:0];
    end
  end

  assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DATA_W))
    else $error("OSR count above 32");

endmodule

// ==== source/pio_isr.sv ====
// ==========================================================
// Input shift register. Shift amounts of 1 to 32 only
// ==========================================================
module pio_isr
  import pio_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              load,
  input  logic              shift,
  input  logic              in_shift_right,
  input  logic [DATA_W-1:0] value,
  input  logic [CNT_W-1:0]  bit_count,
  output logic [DATA_W-1:0] q,
  output logic [CNT_W-1:0]  count
);

  logic [DATA_W-1:0] fill;
  logic [DATA_W-1:0] shifted;
  logic [CNT_W:0]    sum;

  assign fill    = value & low_mask(bit_count);
  assign shifted = in_shift_right ? (q >> bit_count) | (fill << (DATA_W - bit_count))
                                  : (q << bit_count) | fill;
  assign sum     = {1'b0, count} + {1'b0, bit_count};

  always_ff @(posedge clk) begin
    if (rst) begin
      q     <= '0;
      count <= '0;
    end else if (load) begin
      q     <= value;
      count <= bit_count;
    end else if (shift) begin
      q     <= shifted;
      count <= (sum > (CNT_W + 1)'(DATA_W)) ? CNT_W'(DATA_W) : sum[CNT_W-1:0];  // Saturate
    end
  end

  assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DATA_W))
    else $error("ISR count above 32");

endmodule

// ==== source/pio_scratch.sv ====
// ==========================================================
// Scratch register; load and dec never arrive together
// ==========================================================
module pio_scratch
  import pio_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              load,
  input  logic              dec,
  input  logic [DATA_W-1:0] value,
  output logic [DATA_W-1:0] q
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (load) begin
      q <= value;
    end else if (dec) begin
      q <= q - 1'b1;  // Wraps from 0 to all ones
    end
  end

endmodule

// ==== source/pio_pkg.sv ====
// ==========================================================
// Shared types for one PIO state machine. Encoding follows the
// RP2040 PIO layout without side-set; bits [12:8] are delay only
// ==========================================================
package pio_pkg;

  localparam int DATA_W  = 32;
  localparam int PC_W    = 5;
  localparam int INSTR_W = 16;
  localparam int DELAY_W = 5;
  localparam int PIN_W   = 5;  // Pin index
  localparam int CNT_W   = 6;  // Bit counts 0 to 32

  typedef enum logic [2:0] {
    OP_JMP, OP_WAIT, OP_IN, OP_OUT, OP_PUSH_PULL, OP_MOV, OP_IRQ, OP_SET
  } op_e;

  typedef enum logic [2:0] {
    COND_ALWAYS, COND_X_ZERO, COND_X_DEC, COND_Y_ZERO,
    COND_Y_DEC, COND_X_NE_Y, COND_PIN, COND_NOT_OSRE
  } jmp_cond_e;

  typedef enum logic [2:0] {
    SRC_PINS = 3'd0,
    SRC_X    = 3'd1,
    SRC_Y    = 3'd2,
    SRC_NULL = 3'd3,
    SRC_ISR  = 3'd6,
    SRC_OSR  = 3'd7
  } src_e;

  typedef enum logic [2:0] {
    DST_PINS, DST_X, DST_Y, DST_NULL, DST_PINDIRS, DST_PC, DST_ISR, DST_OSR
  } dst_e;

  typedef enum logic [1:0] {
    MOV_NONE, MOV_INVERT, MOV_REVERSE, MOV_RSVD
  } mov_op_e;

  typedef struct packed {
    op_e                opcode;
    logic [DELAY_W-1:0] delay;
    jmp_cond_e          cond;
    logic [PC_W-1:0]    addr;
  } jmp_view_t;

  typedef struct packed {
    op_e                opcode;
    logic [DELAY_W-1:0] delay;
    dst_e               dest;
    mov_op_e            mov_op;
    src_e               src;
  } mov_view_t;

  typedef struct packed {
    op_e                opcode;
    logic [DELAY_W-1:0] delay;
    logic [2:0]         sel;        // Source for IN, destination for OUT
    logic [4:0]         bit_count;  // 0 means 32
  } shift_view_t;

  typedef struct packed {
    op_e                opcode;
    logic [DELAY_W-1:0] delay;
    logic               is_pull;
    logic               rsvd;
    logic               block;
    logic [4:0]         unused;
  } fifo_view_t;

  typedef struct packed {
    op_e                opcode;
    logic [DELAY_W-1:0] delay;
    dst_e               dest;
    logic [4:0]         data;
  } set_view_t;

  typedef union packed {
    jmp_view_t   jmp_v;
    mov_view_t   mov_v;
    shift_view_t shift_v;
    fifo_view_t  fifo_v;
    set_view_t   set_v;
  } instr_u;

  typedef struct packed {
    logic [PC_W-1:0]  wrap_target;
    logic [PC_W-1:0]  wrap_end;
    logic [PIN_W-1:0] out_base;
    logic [CNT_W-1:0] out_count;
    logic [PIN_W-1:0] set_base;
    logic [2:0]       set_count;
    logic [PIN_W-1:0] in_base;
    logic [PIN_W-1:0] jmp_pin;
    logic             in_shift_right;
    logic             out_shift_right;
    logic [4:0]       osr_threshold;  // 0 means 32
  } sm_cfg_t;

  typedef struct packed {
    logic [DATA_W-1:0] value;
    logic [CNT_W-1:0]  bit_count;
    logic              set_x, set_y;          // Scratch loads
    logic              dec_x, dec_y;
    logic              load_isr, shift_isr;
    logic              load_osr, shift_osr;
    logic              jmp;                   // PC takes value
    logic              pins, dirs;
    logic [PIN_W-1:0]  pin_base;
    logic [CNT_W-1:0]  pin_count;
  } sm_wb_t;

  function automatic logic [DATA_W-1:0] reverse_bits(input logic [DATA_W-1:0] w);
    logic [DATA_W-1:0] r;
    for (int i = 0; i < DATA_W; i++) begin
      r[i] = w[DATA_W-1-i];
    end
    return r;
  endfunction

  // Low n bits set, n from 0 to 32
  function automatic logic [DATA_W-1:0] low_mask(input logic [CNT_W-1:0] n);
    return (n >= CNT_W'(DATA_W)) ? {DATA_W{1'b1}} : (DATA_W'(1) << n) - DATA_W'(1);
  endfunction

  function automatic logic [DATA_W-1:0] rotate_left(input logic [DATA_W-1:0] w,
                                                    input logic [PIN_W-1:0]  amt);
    logic [2*DATA_W-1:0] d;
    d = {w, w} << amt;
    return d[2*DATA_W-1:DATA_W];
  endfunction

endpackage
